//--- bench/tb_rv_top.sv
// program below 0x200, results at 0x200, markers at 0x300, host scratch at 0x380; 1 KiB memory
`timescale 1ns/1ps

module tb_rv_top;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP = 7'b0110011;

    localparam logic [31:0] RES_BASE = 32'h200;
    localparam logic [31:0] MARK_BASE = 32'h300;
    localparam logic [31:0] SCRATCH_BASE = 32'h380;
    // register contents that the program sets up first
    localparam logic [31:0] X1 = 32'h8765_4321;
    localparam logic [31:0] X2 = 32'hFFFF_FFFB;
    localparam logic [31:0] X3 = 32'h0000_0007;
    localparam logic [31:0] CLOBBER = 32'h0000_05AD;

    // code region bound and worst cycles per instruction (3 + 2 for memory + 2 lost grants)
    localparam int CODE_WORDS = 128;
    localparam int WORST_CPI = 7;
    // load, fill and readback accesses take about four cycles each
    localparam int HOST_OPS = CODE_WORDS + 128 + 64;
    localparam int WATCHDOG_CYCLES = 2 * (CODE_WORDS * WORST_CPI + HOST_OPS * 4) + 100;

    logic        clock;
    logic        rst_n;
    logic        run;
    logic        host_req;
    logic        host_we;
    logic [31:0] host_addr;
    logic [31:0] host_wdata;
    logic [31:0] host_rdata;
    logic        host_gnt;
    logic        halted;
    logic [31:0] pc;

    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_val [$];
    logic [31:0] image [256];
    logic [31:0] ecall_addr;
    int          n_res;
    int          n_mark;
    integer      seed;

    rv_top #(.MEM_WORDS(256)) dut0
    (
        .clock      (clock),
        .rst_n      (rst_n),
        .run        (run),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .host_gnt   (host_gnt),
        .halted     (halted),
        .pc         (pc)
    );

    always #2 clock = ~clock;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERR %s got %h exp %h", name, got, exp);
            abort_run();
        end
    endtask

    // instruction formats
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    // SW only
    function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // branch condition by funct3
    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // preload word that differs for every address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {~addr[15:0] ^ addr[31:16], addr[15:0]};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    // SW of one register into the next result slot
    task automatic emit_store(input logic [4:0] rs, input logic [31:0] value);
        emit(enc_s(32'(n_res * 4), rs, 5'd20));
        exp_addr.push_back(RES_BASE + 32'(n_res * 4));
        exp_val.push_back(value);
        n_res++;
    endtask

    task automatic emit_result(input logic [31:0] w, input logic [31:0] value);
        emit(w);
        emit_store(5'd10, value);
    endtask

    // marker store that keeps its preload only when jumped over
    task automatic emit_marker(input logic skipped);
        logic [31:0] mark;
        mark = MARK_BASE + 32'(n_mark * 4);
        emit(enc_s(32'(n_mark * 4), 5'd22, 5'd21));
        exp_addr.push_back(mark);
        exp_val.push_back(skipped ? fill_word(mark) : CLOBBER);
        n_mark++;
    endtask

    task automatic emit_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [31:0] a, input logic [31:0] b);
        emit(enc_b(32'd8, rs2, rs1, f3));
        emit_marker(branch_taken(f3, a, b));
    endtask

    task automatic build_program();
        logic [31:0] at;
        // operands in x1 to x3, result base, marker base and clobber value in x20 to x22
        emit(enc_u(20'h87654, 5'd1, OPC_LUI));
        emit(enc_i(32'h321, 5'd1, 3'b000, 5'd1, OPC_IMM));
        emit(enc_i(-5, 5'd0, 3'b000, 5'd2, OPC_IMM));
        emit(enc_i(X3, 5'd0, 3'b000, 5'd3, OPC_IMM));
        emit(enc_i(RES_BASE, 5'd0, 3'b000, 5'd20, OPC_IMM));
        emit(enc_i(MARK_BASE, 5'd0, 3'b000, 5'd21, OPC_IMM));
        emit(enc_i(CLOBBER, 5'd0, 3'b000, 5'd22, OPC_IMM));
        // in the OP group SLL by x2 uses only its low five bits
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd10, OPC_OP), X1 + X2);
        emit_result(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd10, OPC_OP), X1 - X2);
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd10, OPC_OP), X1 << X2[4:0]);
        emit_result(enc_r(7'h00, 5'd3, 5'd2, 3'b010, 5'd10, OPC_OP),
                    {31'b0, $signed(X2) < $signed(X3)});
        emit_result(enc_r(7'h00, 5'd3, 5'd2, 3'b011, 5'd10, OPC_OP), {31'b0, X2 < X3});
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd10, OPC_OP), X1 ^ X2);
        emit_result(enc_r(7'h00, 5'd3, 5'd1, 3'b101, 5'd10, OPC_OP), X1 >> X3[4:0]);
        emit_result(enc_r(7'h20, 5'd3, 5'd1, 3'b101, 5'd10, OPC_OP), $signed(X1) >>> X3[4:0]);
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd10, OPC_OP), X1 | X2);
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd10, OPC_OP), X1 & X2);
        // OP-IMM with negative immediates and an SRAI that carries bit 30
        emit_result(enc_i(-100, 5'd1, 3'b000, 5'd10, OPC_IMM), X1 + 32'hFFFF_FF9C);
        emit_result(enc_i(-4, 5'd2, 3'b010, 5'd10, OPC_IMM),
                    {31'b0, $signed(X2) < $signed(32'hFFFF_FFFC)});
        emit_result(enc_i(-4, 5'd2, 3'b011, 5'd10, OPC_IMM), {31'b0, X2 < 32'hFFFF_FFFC});
        emit_result(enc_i(-1, 5'd1, 3'b100, 5'd10, OPC_IMM), ~X1);
        emit_result(enc_i(32'h0F0, 5'd1, 3'b110, 5'd10, OPC_IMM), X1 | 32'h0000_00F0);
        emit_result(enc_i(-256, 5'd1, 3'b111, 5'd10, OPC_IMM), X1 & 32'hFFFF_FF00);
        emit_result(enc_i(32'd4, 5'd1, 3'b001, 5'd10, OPC_IMM), X1 << 4);
        emit_result(enc_i(32'd12, 5'd1, 3'b101, 5'd10, OPC_IMM), X1 >> 12);
        emit_result(enc_i(32'h40C, 5'd1, 3'b101, 5'd10, OPC_IMM), $signed(X1) >>> 12);
        emit_result(enc_u(20'hABCDE, 5'd10, OPC_LUI), {20'hABCDE, 12'h000});
        emit_result(enc_u(20'h00010, 5'd10, OPC_AUIPC), 32'(prog.size() * 4) + 32'h0001_0000);
        // LW of the first result slot
        emit(enc_i(32'd0, 5'd20, 3'b010, 5'd11, OPC_LOAD));
        emit_store(5'd11, X1 + X2);
        // taken then not taken for every compare
        emit_branch(3'b000, 5'd3, 5'd3, X3, X3);
        emit_branch(3'b000, 5'd2, 5'd3, X2, X3);
        emit_branch(3'b001, 5'd2, 5'd3, X2, X3);
        emit_branch(3'b001, 5'd3, 5'd3, X3, X3);
        emit_branch(3'b100, 5'd2, 5'd3, X2, X3);
        emit_branch(3'b100, 5'd3, 5'd2, X3, X2);
        emit_branch(3'b101, 5'd3, 5'd2, X3, X2);
        emit_branch(3'b101, 5'd2, 5'd3, X2, X3);
        emit_branch(3'b110, 5'd3, 5'd2, X3, X2);
        emit_branch(3'b110, 5'd2, 5'd3, X2, X3);
        emit_branch(3'b111, 5'd2, 5'd3, X2, X3);
        emit_branch(3'b111, 5'd3, 5'd2, X3, X2);
        // JAL over one marker links the next pc
        at = 32'(prog.size() * 4);
        emit(enc_j(32'd8, 5'd5));
        emit_marker(1'b1);
        emit_store(5'd5, at + 32'd4);
        // JALR to x6 + 13 drops the low bit and lands past the marker
        at = 32'(prog.size() * 4);
        emit(enc_u(20'h00000, 5'd6, OPC_AUIPC));
        emit(enc_i(32'd13, 5'd6, 3'b000, 5'd7, OPC_JALR));
        emit_marker(1'b1);
        emit_store(5'd7, at + 32'd8);
        ecall_addr = 32'(prog.size() * 4);
        emit(32'h0000_0073);
    endtask

    // one host bus cycle holds the request until granted and samples the read word a cycle later
    task automatic host_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                               output logic [31:0] rdata);
        int waits;
        waits = 0;
        @(posedge clock);
        #1;
        host_req = 1'b1;
        host_we = we;
        host_addr = addr;
        host_wdata = wdata;
        @(negedge clock);
        while (!host_gnt)
        begin
            // a refused cycle is a grant to the core
            waits++;
            assert (waits < 2)
            else
            begin
                $display("host request to %h was passed over by two core grants", addr);
                abort_run();
            end
            @(negedge clock);
        end
        @(posedge clock);
        #1;
        host_req = 1'b0;
        host_we = 1'b0;
        @(negedge clock);
        rdata = host_rdata;
    endtask

    task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        host_access(1'b1, addr, data, unused);
        image[addr[9:2]] = data;
    endtask

    initial
    begin
        int          i;
        logic [31:0] got;
        logic [31:0] rnd;
        logic [31:0] addr;
        clock = 1'b0;
        rst_n = 1'b0;
        run = 1'b0;
        host_req = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        seed = 32'h58aa_9aa4;
        n_res = 0;
        n_mark = 0;
        build_program();
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;
        @(negedge clock);
        check_value("halted", {31'b0, halted}, 32'd0);
        check_value("host_gnt", {31'b0, host_gnt}, 32'd0);
        check_value("pc", pc, 32'd0);

        // program and then the whole data region while the core idles
        for (i = 0; i < prog.size(); i++)
        begin
            host_write(32'(i * 4), prog[i]);
            check_value("pc", pc, 32'd0);
        end
        for (i = 128; i < 256; i++)
        begin
            host_write(32'(i * 4), fill_word(32'(i * 4)));
            check_value("pc", pc, 32'd0);
        end

        @(posedge clock);
        #1;
        run = 1'b1;
        // scratch reads compete with the core until it halts
        while (!halted)
        begin
            rnd = $random(seed);
            repeat (rnd[9:8]) @(negedge clock);
            addr = SCRATCH_BASE + {25'b0, rnd[4:0], 2'b00};
            host_access(1'b0, addr, 32'd0, got);
            check_value($sformatf("host_rdata[%h]", addr), got, image[addr[9:2]]);
        end

        check_value("pc", pc, ecall_addr);
        repeat (5)
        begin
            @(negedge clock);
            check_value("halted", {31'b0, halted}, 32'd1);
        end
        for (i = 0; i < exp_addr.size(); i++)
        begin
            host_access(1'b0, exp_addr[i], 32'd0, got);
            check_value($sformatf("host_rdata[%h]", exp_addr[i]), got, exp_val[i]);
            check_value("halted", {31'b0, halted}, 32'd1);
        end

        $display("Done: no errors");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout after %0d clock cycles without reaching the end", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

//--- hdl/alu.sv
// combinational ALU; shifts use b[4:0], result is zero on branch compares
`timescale 1ns/1ps

module alu
(
    input  rv_isa_pkg::alu_op_e op,
    input  rv_bus_pkg::xlen_t   a,
    input  rv_bus_pkg::xlen_t   b,
    output rv_bus_pkg::xlen_t   result,
    output logic                taken
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    // both compares are shared by SLT(U) and the branches
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb
    begin
        result = '0;
        taken = 1'b0;
        case (op)
            rv_isa_pkg::ALU_ADD:    result = a + b;
            rv_isa_pkg::ALU_SUB:    result = a - b;
            rv_isa_pkg::ALU_SLL:    result = a << shamt;
            rv_isa_pkg::ALU_SLT:    result = {31'b0, lt_s};
            rv_isa_pkg::ALU_SLTU:   result = {31'b0, lt_u};
            rv_isa_pkg::ALU_XOR:    result = a ^ b;
            rv_isa_pkg::ALU_SRL:    result = a >> shamt;
            rv_isa_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            rv_isa_pkg::ALU_OR:     result = a | b;
            rv_isa_pkg::ALU_AND:    result = a & b;
            rv_isa_pkg::ALU_PASS_B: result = b;
            rv_isa_pkg::ALU_EQ:     taken = (a == b);
            rv_isa_pkg::ALU_NE:     taken = (a != b);
            rv_isa_pkg::ALU_LT:     taken = lt_s;
            rv_isa_pkg::ALU_GE:     taken = !lt_s;
            rv_isa_pkg::ALU_LTU:    taken = lt_u;
            rv_isa_pkg::ALU_GEU:    taken = !lt_u;
            default:                result = '0;
        endcase
    end

endmodule

//--- hdl/core_ctrl.sv
// multicycle RV32I sequencer; starts on run, stops for good on ECALL/EBREAK until reset
`timescale 1ns/1ps

module core_ctrl
(
    input  logic              clock,
    input  logic              rst_n,
    input  logic              run,
    mem_bus_if.requester      bus,
    output logic              halted,
    output rv_bus_pkg::xlen_t pc
);

    typedef enum logic [2:0]
    {
        IDLE, FETCH, CAPTURE, EXEC, MEM, LOAD_WB, HALT
    } state_e;

    state_e            state;
    rv_bus_pkg::xlen_t ir;
    rv_isa_pkg::dec_t  dec;
    rv_bus_pkg::xlen_t rdata1;
    rv_bus_pkg::xlen_t rdata2;
    rv_bus_pkg::xlen_t alu_a;
    rv_bus_pkg::xlen_t alu_b;
    rv_bus_pkg::xlen_t alu_result;
    logic              taken;
    rv_bus_pkg::xlen_t pc_plus4;
    rv_bus_pkg::xlen_t pc_imm;
    rv_bus_pkg::xlen_t next_pc;
    logic              rf_we;
    rv_bus_pkg::xlen_t rf_wdata;

    decode u_decode (.instruction(ir), .dec(dec));

    regfile u_regfile
    (
        .clock  (clock),
        .rst_n  (rst_n),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .rd     (dec.rd),
        .wdata  (rf_wdata)
    );

    // operand a is the pc only for AUIPC
    assign alu_a = dec.is_auipc ? pc : rdata1;
    assign alu_b = dec.alu_src_imm ? dec.imm : rdata2;

    alu u_alu (.op(dec.alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .taken(taken));

    assign pc_plus4 = pc + 32'd4;
    // branch and JAL target share one adder
    assign pc_imm = pc + dec.imm;

    always_comb
    begin
        if (dec.is_jal || (dec.is_branch && taken))
            next_pc = pc_imm;
        else if (dec.is_jalr)
            next_pc = {alu_result[31:1], 1'b0};
        else
            next_pc = pc_plus4;
    end

    // ALU results write in EXEC and load data one state later
    assign rf_we = ((state == EXEC) && dec.reg_write && !dec.is_load) ||
                   ((state == LOAD_WB) && dec.is_load);

    // LUI passes its upper immediate through the ALU
    always_comb
    begin
        if (state == LOAD_WB)
            rf_wdata = bus.rdata;
        else if (dec.is_jal || dec.is_jalr)
            rf_wdata = pc_plus4;
        else
            rf_wdata = alu_result;
    end

    // ir and regs hold still through MEM, so the ALU keeps the data address valid
    assign bus.req = (state == FETCH) || (state == MEM);
    assign bus.we = (state == MEM) && dec.is_store;
    assign bus.addr = (state == MEM) ? {alu_result[31:2], 2'b00} : {pc[31:2], 2'b00};
    assign bus.wdata = rdata2;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
            pc <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (run)
                        state <= FETCH;
                FETCH:
                    if (bus.gnt)
                        state <= CAPTURE;
                CAPTURE:
                    state <= EXEC;
                EXEC:
                begin
                    // halt keeps the pc on the ECALL/EBREAK
                    if (dec.is_halt)
                    begin
                        state <= HALT;
                    end
                    else
                    begin
                        pc <= next_pc;
                        state <= (dec.is_load || dec.is_store) ? MEM : FETCH;
                    end
                end
                MEM:
                    if (bus.gnt)
                        state <= LOAD_WB;
                LOAD_WB:
                    state <= FETCH;
                default:
                    state <= HALT;
            endcase
        end
    end

    // instruction word arrives the cycle after the fetch grant
    always_ff @(posedge clock)
    begin
        if (state == CAPTURE)
            ir <= bus.rdata;
    end

    assign halted = (state == HALT);

endmodule

//--- hdl/decode.sv
// combinational RV32I decode; unknown opcodes come out as a nop with no flags set
`timescale 1ns/1ps

module decode
(
    input  rv_bus_pkg::xlen_t instruction,
    output rv_isa_pkg::dec_t  dec
);

    // one immediate per format, sign always from bit 31
    rv_bus_pkg::xlen_t imm_i;
    rv_bus_pkg::xlen_t imm_s;
    rv_bus_pkg::xlen_t imm_b;
    rv_bus_pkg::xlen_t imm_u;
    rv_bus_pkg::xlen_t imm_j;
    logic              f7_b5;
    logic              is_op_imm;

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    // branch offset is bits 12|10:5|4:1|11, bit 0 always zero
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    // jump offset is bits 20|10:1|11|19:12
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    // funct7 bit 5 marks SUB and SRA
    assign f7_b5 = instruction[30];
    assign is_op_imm = (instruction[6:0] == rv_isa_pkg::OP_IMM);

    always_comb
    begin
        // register and funct fields sit at fixed places in every format
        dec = '0;
        dec.opcode = rv_isa_pkg::opcode_e'(instruction[6:0]);
        dec.rd = instruction[11:7];
        dec.funct3 = instruction[14:12];
        dec.rs1 = instruction[19:15];
        dec.rs2 = instruction[24:20];
        dec.fmt = rv_isa_pkg::FMT_R;
        dec.alu_op = rv_isa_pkg::ALU_ADD;

        case (dec.opcode)
            rv_isa_pkg::OP_LUI:
            begin
                dec.fmt = rv_isa_pkg::FMT_U;
                dec.alu_op = rv_isa_pkg::ALU_PASS_B;
                dec.alu_src_imm = 1'b1;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OP_AUIPC:
            begin
                // pc + upper immediate
                dec.fmt = rv_isa_pkg::FMT_U;
                dec.alu_src_imm = 1'b1;
                dec.reg_write = 1'b1;
                dec.is_auipc = 1'b1;
            end
            rv_isa_pkg::OP_JAL:
            begin
                dec.fmt = rv_isa_pkg::FMT_J;
                dec.reg_write = 1'b1;
                dec.is_jal = 1'b1;
            end
            rv_isa_pkg::OP_JALR:
            begin
                // target rs1 + imm goes through the ALU
                dec.fmt = rv_isa_pkg::FMT_I;
                dec.alu_src_imm = 1'b1;
                dec.reg_write = 1'b1;
                dec.is_jalr = 1'b1;
            end
            rv_isa_pkg::OP_BRANCH:
            begin
                dec.fmt = rv_isa_pkg::FMT_B;
                dec.is_branch = 1'b1;
                case (dec.funct3)
                    3'b001:  dec.alu_op = rv_isa_pkg::ALU_NE;
                    3'b100:  dec.alu_op = rv_isa_pkg::ALU_LT;
                    3'b101:  dec.alu_op = rv_isa_pkg::ALU_GE;
                    3'b110:  dec.alu_op = rv_isa_pkg::ALU_LTU;
                    3'b111:  dec.alu_op = rv_isa_pkg::ALU_GEU;
                    default: dec.alu_op = rv_isa_pkg::ALU_EQ;
                endcase
            end
            rv_isa_pkg::OP_LOAD:
            begin
                // only LW, funct3 is not looked at
                dec.fmt = rv_isa_pkg::FMT_I;
                dec.alu_src_imm = 1'b1;
                dec.reg_write = 1'b1;
                dec.is_load = 1'b1;
            end
            rv_isa_pkg::OP_STORE:
            begin
                dec.fmt = rv_isa_pkg::FMT_S;
                dec.alu_src_imm = 1'b1;
                dec.is_store = 1'b1;
            end
            rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_OP:
            begin
                dec.fmt = is_op_imm ? rv_isa_pkg::FMT_I : rv_isa_pkg::FMT_R;
                dec.alu_src_imm = is_op_imm;
                dec.reg_write = 1'b1;
                case (dec.funct3)
                    // no SUBI, so bit 30 only counts for OP
                    3'b000:  dec.alu_op = (f7_b5 && !is_op_imm) ? rv_isa_pkg::ALU_SUB
                                                                : rv_isa_pkg::ALU_ADD;
                    3'b001:  dec.alu_op = rv_isa_pkg::ALU_SLL;
                    3'b010:  dec.alu_op = rv_isa_pkg::ALU_SLT;
                    3'b011:  dec.alu_op = rv_isa_pkg::ALU_SLTU;
                    3'b100:  dec.alu_op = rv_isa_pkg::ALU_XOR;
                    3'b101:  dec.alu_op = f7_b5 ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
                    3'b110:  dec.alu_op = rv_isa_pkg::ALU_OR;
                    default: dec.alu_op = rv_isa_pkg::ALU_AND;
                endcase
            end
            rv_isa_pkg::OP_SYSTEM:
            begin
                // ECALL and EBREAK share funct3 0, CSR forms are dropped
                dec.fmt = rv_isa_pkg::FMT_I;
                dec.is_halt = (dec.funct3 == 3'b000);
            end
            default:
            begin
                // unknown opcode, all flags stay low and the pc just advances
                dec.fmt = rv_isa_pkg::FMT_R;
            end
        endcase

        // immediate layout follows the format kind
        case (dec.fmt)
            rv_isa_pkg::FMT_I: dec.imm = imm_i;
            rv_isa_pkg::FMT_S: dec.imm = imm_s;
            rv_isa_pkg::FMT_B: dec.imm = imm_b;
            rv_isa_pkg::FMT_U: dec.imm = imm_u;
            rv_isa_pkg::FMT_J: dec.imm = imm_j;
            default:           dec.imm = '0;
        endcase

        // shift immediates carry just the shift amount in the rs2 field
        if (is_op_imm && (dec.funct3[1:0] == 2'b01))
        begin
            dec.imm = {27'b0, instruction[24:20]};
        end
    end

endmodule

//--- hdl/mem_arbiter.sv
// two-way alternating arbiter, combinational grant, one request per cycle to memory
`timescale 1ns/1ps

module mem_arbiter
(
    input  logic         clock,
    input  logic         rst_n,
    mem_bus_if.memory    core_bus,
    mem_bus_if.memory    host_bus,
    mem_bus_if.requester mem_bus
);

    rv_bus_pkg::req_src_e last_src;
    logic                 pick_host;

    // on a tie the side not granted last wins
    assign pick_host = host_bus.req && (!core_bus.req || (last_src == rv_bus_pkg::SRC_CORE));

    assign mem_bus.req = core_bus.req || host_bus.req;
    assign mem_bus.we = pick_host ? host_bus.we : core_bus.we;
    assign mem_bus.addr = pick_host ? host_bus.addr : core_bus.addr;
    assign mem_bus.wdata = pick_host ? host_bus.wdata : core_bus.wdata;

    assign host_bus.gnt = mem_bus.gnt && pick_host;
    assign core_bus.gnt = mem_bus.gnt && !pick_host;

    // last_src also tells whose read data comes back this cycle
    assign core_bus.rdata = (last_src == rv_bus_pkg::SRC_CORE) ? mem_bus.rdata : '0;
    assign host_bus.rdata = (last_src == rv_bus_pkg::SRC_HOST) ? mem_bus.rdata : '0;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            last_src <= rv_bus_pkg::SRC_HOST;
        else if (mem_bus.gnt)
            last_src <= pick_host ? rv_bus_pkg::SRC_HOST : rv_bus_pkg::SRC_CORE;
    end

endmodule

//--- hdl/mem_bus_if.sv
// request/grant word bus; requester holds req and fields until gnt, read data one cycle later
`timescale 1ns/1ps

interface mem_bus_if;

    // request side
    logic                          req;
    logic                          we;
    logic [rv_bus_pkg::ADDR_W-1:0] addr;
    rv_bus_pkg::xlen_t             wdata;

    // memory side
    rv_bus_pkg::xlen_t             rdata;
    logic                          gnt;

    modport requester (output req, we, addr, wdata, input rdata, gnt);

    modport memory (input req, we, addr, wdata, output rdata, gnt);

endinterface

//--- hdl/regfile.sv
// 31 x 32-bit registers, combinational reads, x0 reads zero and ignores writes
`timescale 1ns/1ps

module regfile
(
    input  logic              clock,
    input  logic              rst_n,
    input  logic [4:0]        rs1,
    input  logic [4:0]        rs2,
    output rv_bus_pkg::xlen_t rdata1,
    output rv_bus_pkg::xlen_t rdata2,
    input  logic              we,
    input  logic [4:0]        rd,
    input  rv_bus_pkg::xlen_t wdata
);

    // x0 has no storage
    rv_bus_pkg::xlen_t regs [1:31];

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && (rd != 5'd0))
        begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- hdl/rv_bus_pkg.sv
// word bus definitions; only 32-bit words, byte addresses whose low two bits memory ignores
package rv_bus_pkg;

    // data word of the core, the buses and the memory
    typedef logic [31:0] xlen_t;

    // byte address width on every bus
    localparam int ADDR_W = 32;

    // owner of a bus cycle, also the arbiter's last-granted flag
    typedef enum logic
    {
        SRC_CORE = 1'b0,
        SRC_HOST = 1'b1
    } req_src_e;

endpackage

//--- hdl/rv_isa_pkg.sv
// RV32I encodings for the kept subset; no FENCE, CSR, byte or halfword access
package rv_isa_pkg;

    // major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0]
    {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // format kind, picks the immediate layout
    typedef enum logic [2:0]
    {
        FMT_R = 3'd0,
        FMT_I = 3'd1,
        FMT_S = 3'd2,
        FMT_B = 3'd3,
        FMT_U = 3'd4,
        FMT_J = 3'd5
    } fmt_e;

    // ALU operations, the last six only drive the branch flag
    typedef enum logic [4:0]
    {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_op_e;

    // everything the sequencer needs from one instruction word
    typedef struct packed
    {
        opcode_e           opcode;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [2:0]        funct3;
        rv_bus_pkg::xlen_t imm;
        fmt_e              fmt;
        alu_op_e           alu_op;
        logic              alu_src_imm;
        logic              reg_write;
        logic              is_load;
        logic              is_store;
        logic              is_branch;
        logic              is_jal;
        logic              is_jalr;
        logic              is_auipc;
        logic              is_halt;
    } dec_t;

endpackage

//--- hdl/rv_top.sv
// core, arbiter and memory; host port shares memory with the core, host_rdata one cycle after host_gnt
`timescale 1ns/1ps

module rv_top
#(
    parameter int MEM_WORDS = 256
)
(
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic                          host_req,
    input  logic                          host_we,
    input  logic [rv_bus_pkg::ADDR_W-1:0] host_addr,
    input  rv_bus_pkg::xlen_t             host_wdata,
    output rv_bus_pkg::xlen_t             host_rdata,
    output logic                          host_gnt,
    output logic                          halted,
    output rv_bus_pkg::xlen_t             pc
);

    mem_bus_if core_bus ();
    mem_bus_if host_bus ();
    mem_bus_if mem_bus ();

    // host pins onto its bus
    assign host_bus.req = host_req;
    assign host_bus.we = host_we;
    assign host_bus.addr = host_addr;
    assign host_bus.wdata = host_wdata;
    assign host_rdata = host_bus.rdata;
    assign host_gnt = host_bus.gnt;

    core_ctrl u_core
    (
        .clock  (clock),
        .rst_n  (rst_n),
        .run    (run),
        .bus    (core_bus.requester),
        .halted (halted),
        .pc     (pc)
    );

    mem_arbiter u_arb
    (
        .clock    (clock),
        .rst_n    (rst_n),
        .core_bus (core_bus.memory),
        .host_bus (host_bus.memory),
        .mem_bus  (mem_bus.requester)
    );

    word_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (.clock(clock), .bus(mem_bus.memory));

endmodule

//--- hdl/word_mem.sv
// single-port word RAM, always grants, contents undefined until the host writes them
`timescale 1ns/1ps

module word_mem
#(
    parameter int MEM_WORDS = 256
)
(
    input logic       clock,
    mem_bus_if.memory bus
);

    rv_bus_pkg::xlen_t             mem [MEM_WORDS];
    logic [rv_bus_pkg::ADDR_W-1:0] word_idx;

    // word index wraps at the memory size
    assign word_idx = (bus.addr >> 2) % rv_bus_pkg::ADDR_W'(MEM_WORDS);

    assign bus.gnt = bus.req;

    always_ff @(posedge clock)
    begin
        if (bus.req && bus.we)
            mem[word_idx] <= bus.wdata;
        // read word is ready the cycle after the grant
        if (bus.req && !bus.we)
            bus.rdata <= mem[word_idx];
    end

endmodule

//--- run.sh
#!/bin/sh
# builds tb_rv_top with Verilator, runs it and fails if the log holds the fail message
cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_rv_top -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

//--- verilog.f
hdl/rv_bus_pkg.sv
hdl/rv_isa_pkg.sv
hdl/mem_bus_if.sv
hdl/decode.sv
hdl/alu.sv
hdl/regfile.sv
hdl/core_ctrl.sv
hdl/mem_arbiter.sv
hdl/word_mem.sv
hdl/rv_top.sv
bench/tb_rv_top.sv
